//--- verilog.f
hdl/soc_pkg.sv
hdl/bus_decoder.sv
hdl/data_ram.sv
hdl/machine_timer.sv
hdl/irq_controller.sv
hdl/uart_tx.sv
hdl/peripherals.sv
hdl/soc_platform.sv
verification/soc_platform_tb.sv

//--- verification/soc_platform_tb.sv
module soc_platform_tb;
    import soc_pkg::*;

    localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
    localparam logic [31:0] RTC_BASE  = 32'h2000_0000;
    localparam logic [31:0] PLIC_BASE = 32'h3000_0000;
    localparam logic [31:0] PER_BASE  = 32'h8000_0000;
    localparam int          LIMIT     = 400;   // cycles allowed for any single wait

    typedef enum logic [3:0] {
        OP_WR, OP_RD, OP_RDM, OP_RDINC, OP_IDLE, OP_BTN, OP_ACK, OP_UART, OP_MTI, OP_MEI
    } op_kind_e;

    typedef struct packed {
        op_kind_e    kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp;   // expected value, or minimum stall cycles for a write
    } op_t;

    logic        clk;
    logic        arst_n_i;
    mem_req_t    mem_req;
    logic [31:0] rdata;
    logic        stall;
    logic        interrupt_ack;
    logic        button;
    logic        mti;
    logic        mei;
    logic        uart_tx;

    op_t         ops [$];
    logic [31:0] ram_model [256];
    logic [7:0]  uart_frames [$];
    logic [31:0] rng_state = 32'hdde9;
    logic [31:0] mtime_seen;

    soc_platform dut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .mem_req_i       (mem_req),
        .rdata_o         (rdata),
        .stall_o         (stall),
        .interrupt_ack_i (interrupt_ack),
        .button_i        (button),
        .mti_o           (mti),
        .mei_o           (mei),
        .uart_tx_o       (uart_tx)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_op(input op_kind_e kind, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          input logic [31:0] exp);
        ops.push_back('{kind: kind, addr: addr, data: data, strb: strb, exp: exp});
    endtask

    task automatic give_up(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_min(input string name, input logic [31:0] got, input logic [31:0] lo);
        assert (got >= lo) else begin
            $display("Error at time %0t: %s is %0d, expected at least %0d", $time, name, got, lo);
            $display("TEST FAILED");
            $fatal(1, "value below bound");
        end
    endtask

    ////////////////////////////////////////
    // bus master
    ////////////////////////////////////////
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output int stalls);
        stalls = 0;
        @(posedge clk);
        #2;
        mem_req = '{en: 1'b1, we: strb, addr: addr, wdata: data};
        @(negedge clk);
        while (stall) begin   // request held unchanged while stalled
            stalls++;
            if (stalls > LIMIT) begin
                give_up("Timeout waiting for stall_o to drop on a write");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        mem_req = '0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int guard;
        guard = 0;
        @(posedge clk);
        #2;
        mem_req = '{en: 1'b1, we: 4'b0, addr: addr, wdata: 32'b0};
        @(negedge clk);
        while (stall) begin
            guard++;
            if (guard > LIMIT) begin
                give_up("Timeout waiting for stall_o to drop on a read");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        mem_req = '0;
        @(negedge clk);
        data = rdata;   // one cycle after the accepting edge
    endtask

    task automatic press_button();
        @(posedge clk);
        #2;
        button = 1'b1;
        repeat (6) @(posedge clk);   // covers the synchronizer and the pending flop
        #2;
        button = 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_ack();
        @(posedge clk);
        #2;
        interrupt_ack = 1'b1;
        @(posedge clk);
        #2;
        interrupt_ack = 1'b0;
    endtask

    task automatic wait_frame(output logic [7:0] data);
        int guard;
        guard = 0;
        while (uart_frames.size() == 0) begin
            guard++;
            if (guard > LIMIT) begin
                give_up("Timeout waiting for a UART frame");
            end
            @(negedge clk);
        end
        data = uart_frames.pop_front();
    endtask

    // samples the line in the middle of each bit
    always begin : uart_monitor
        logic [7:0] rx_byte;
        @(negedge clk);
        if (arst_n_i === 1'b1 && uart_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_eq("uart_tx_o start bit", 32'(uart_tx), 32'h0);
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[b] = uart_tx;   // lsb first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_eq("uart_tx_o stop bit", 32'(uart_tx), 32'h1);
            uart_frames.push_back(rx_byte);
        end
    end

    ////////////////////////////////////////
    // operation table
    ////////////////////////////////////////
    task automatic build_table();
        // ram, full words then single bytes
        add_op(OP_WR, RAM_BASE + 32'h0, lcg_next(), 4'b1111, 32'h0);
        add_op(OP_WR, RAM_BASE + 32'h4, lcg_next(), 4'b1111, 32'h0);
        add_op(OP_WR, RAM_BASE + 32'h8, lcg_next(), 4'b1111, 32'h0);
        add_op(OP_WR, RAM_BASE + 32'h4, 32'h0000_5A00, 4'b0010, 32'h0);
        add_op(OP_WR, RAM_BASE + 32'h8, 32'hC300_0000, 4'b1000, 32'h0);
        add_op(OP_RDM, RAM_BASE + 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RDM, RAM_BASE + 32'h4, 32'h0, 4'b0, 32'h0);
        add_op(OP_RDM, RAM_BASE + 32'h8, 32'h0, 4'b0, 32'h0);
        // timer
        add_op(OP_RDINC, RTC_BASE + 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_IDLE, 32'h0, 32'd5, 4'b0, 32'h0);
        add_op(OP_RDINC, RTC_BASE + 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_WR, RTC_BASE + 32'hC, 32'h0000_0000, 4'b1111, 32'h0);
        add_op(OP_WR, RTC_BASE + 32'h8, 32'h0000_0010, 4'b1111, 32'h0);
        add_op(OP_MTI, 32'h0, 32'h0, 4'b0, 32'h1);
        add_op(OP_WR, RTC_BASE + 32'hC, 32'hFFFF_FFFF, 4'b1111, 32'h0);
        add_op(OP_MTI, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RD, RTC_BASE + 32'hC, 32'h0, 4'b0, 32'hFFFF_FFFF);
        // button interrupt
        add_op(OP_BTN, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_MEI, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RD, PLIC_BASE + 32'h0, 32'h0, 4'b0, 32'h1);
        add_op(OP_WR, PLIC_BASE + 32'h4, 32'h3, 4'b0001, 32'h0);
        add_op(OP_MEI, 32'h0, 32'h0, 4'b0, 32'h1);
        add_op(OP_RD, PLIC_BASE + 32'h8, 32'h0, 4'b0, 32'h1);
        add_op(OP_ACK, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_MEI, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RD, PLIC_BASE + 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RD, 32'h7000_0004, 32'h0, 4'b0, 32'h3);
        // uart, the second write stalls for most of the first frame
        add_op(OP_WR, PER_BASE + 32'h4, 32'hA5, 4'b0001, 32'h0);
        add_op(OP_WR, PER_BASE + 32'h4, 32'h3C, 4'b0001, 32'(9 * CLKS_PER_BIT));
        add_op(OP_UART, 32'h0, 32'h0, 4'b0, 32'hA5);
        add_op(OP_UART, 32'h0, 32'h0, 4'b0, 32'h3C);
        add_op(OP_IDLE, 32'h0, 32'd10, 4'b0, 32'h0);
        // uart done interrupt
        add_op(OP_MEI, 32'h0, 32'h0, 4'b0, 32'h1);
        add_op(OP_RD, PLIC_BASE + 32'h8, 32'h0, 4'b0, 32'h2);
        add_op(OP_ACK, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_MEI, 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RD, PLIC_BASE + 32'h0, 32'h0, 4'b0, 32'h0);
        add_op(OP_RD, PER_BASE + 32'h8, 32'h0, 4'b0, 32'h0);
        // region edges
        add_op(OP_RD, 32'hF000_0000, 32'h0, 4'b0, 32'h0);
        add_op(OP_RDM, 32'h1000_0004, 32'h0, 4'b0, 32'h0);
    endtask

    initial begin
        op_t         op;
        int          stalls;
        logic [31:0] got;
        logic [7:0]  frame;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        mem_req       = '0;
        interrupt_ack = 1'b0;
        button        = 1'b0;
        mtime_seen    = '0;
        build_table();
        repeat (5) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        @(negedge clk);
        check_eq("stall_o", 32'(stall), 32'h0);
        check_eq("mei_o", 32'(mei), 32'h0);
        check_eq("mti_o", 32'(mti), 32'h0);
        check_eq("uart_tx_o", 32'(uart_tx), 32'h1);

        foreach (ops[i]) begin
            op = ops[i];
            case (op.kind)
                OP_WR: begin
                    bus_write(op.addr, op.data, op.strb, stalls);
                    if (op.addr[31:28] < 4'h2) begin
                        ram_model[op.addr[9:2]] =
                            apply_strobes(ram_model[op.addr[9:2]], op.data, op.strb);
                    end
                    if (op.exp == 0) begin
                        check_eq("stall_o cycles", 32'(stalls), 32'h0);
                    end
                    else begin
                        check_min("stall_o cycles", 32'(stalls), op.exp);
                    end
                end
                OP_RD: begin
                    bus_read(op.addr, got);
                    check_eq("rdata_o", got, op.exp);
                end
                OP_RDM: begin
                    bus_read(op.addr, got);
                    check_eq("rdata_o", got, ram_model[op.addr[9:2]]);
                end
                OP_RDINC: begin
                    bus_read(op.addr, got);
                    check_min("rdata_o mtime", got, mtime_seen + 32'd1);
                    mtime_seen = got;
                end
                OP_IDLE: repeat (op.data) @(posedge clk);
                OP_BTN:  press_button();
                OP_ACK:  send_ack();
                OP_UART: begin
                    wait_frame(frame);
                    check_eq("uart_tx_o frame", 32'(frame), op.exp);
                end
                OP_MTI: begin
                    @(negedge clk);
                    check_eq("mti_o", 32'(mti), op.exp);
                end
                OP_MEI: begin
                    @(negedge clk);
                    check_eq("mei_o", 32'(mei), op.exp);
                end
                default: give_up("Unknown operation kind in the table");
            endcase
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- hdl/soc_platform.sv
module soc_platform (
    input  logic              clk,
    input  logic              arst_n_i,
    input  soc_pkg::mem_req_t mem_req_i,
    output logic [31:0]       rdata_o,
    output logic              stall_o,
    input  logic              interrupt_ack_i,
    input  logic              button_i,
    output logic              mti_o,
    output logic              mei_o,
    output logic              uart_tx_o
);
    import soc_pkg::*;

    logic               ram_en;
    logic               rtc_en;
    logic               plic_en;
    logic               per_en;
    logic [31:0]        ram_rdata;
    logic [31:0]        rtc_rdata;
    logic [31:0]        plic_rdata;
    logic [31:0]        per_rdata;
    logic [IRQ_COUNT:1] irq_req;    // peripherals to interrupt controller
    logic [IRQ_COUNT:1] iack;       // and back

    ////////////////////////////////////////
    // address decode and read return
    ////////////////////////////////////////
    bus_decoder u_bus_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mem_req_i    (mem_req_i),
        .ram_en_o     (ram_en),
        .rtc_en_o     (rtc_en),
        .plic_en_o    (plic_en),
        .per_en_o     (per_en),
        .ram_rdata_i  (ram_rdata),
        .rtc_rdata_i  (rtc_rdata),
        .plic_rdata_i (plic_rdata),
        .per_rdata_i  (per_rdata),
        .rdata_o      (rdata_o)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .en_i      (ram_en),
        .mem_req_i (mem_req_i),
        .rdata_o   (ram_rdata)
    );

    machine_timer u_machine_timer (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .en_i      (rtc_en),
        .mem_req_i (mem_req_i),
        .rdata_o   (rtc_rdata),
        .mti_o     (mti_o)
    );

    ////////////////////////////////////////
    // interrupts and i/o
    ////////////////////////////////////////
    irq_controller u_irq_controller (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .en_i            (plic_en),
        .mem_req_i       (mem_req_i),
        .rdata_o         (plic_rdata),
        .irq_i           (irq_req),
        .interrupt_ack_i (interrupt_ack_i),
        .mei_o           (mei_o),
        .iack_o          (iack)
    );

    peripherals u_peripherals (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .en_i      (per_en),
        .mem_req_i (mem_req_i),
        .rdata_o   (per_rdata),
        .stall_o   (stall_o),
        .button_i  (button_i),
        .uart_tx_o (uart_tx_o),
        .irq_o     (irq_req),
        .iack_i    (iack)
    );

endmodule

//--- hdl/peripherals.sv
module peripherals (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        en_i,
    input  soc_pkg::mem_req_t           mem_req_i,
    output logic [31:0]                 rdata_o,
    output logic                        stall_o,
    input  logic                        button_i,
    output logic                        uart_tx_o,
    output logic [soc_pkg::IRQ_COUNT:1] irq_o,
    input  logic [soc_pkg::IRQ_COUNT:1] iack_i
);
    import soc_pkg::*;

    logic               btn_meta_q;
    logic               btn_sync_q;
    logic               btn_prev_q;
    logic [IRQ_COUNT:1] irq_q;
    logic               uart_busy;
    logic               uart_done;
    logic               uart_start;
    logic               data_wr;
    logic               rd;
    logic [7:0]         offset;

    assign offset     = mem_req_i.addr[7:0];
    assign rd         = en_i && !(|mem_req_i.we);
    assign data_wr    = en_i && (|mem_req_i.we) && (offset == PER_UART_DATA);
    assign stall_o    = data_wr && uart_busy;   // hold the master until the line frees
    assign uart_start = data_wr && !uart_busy;
    assign irq_o      = irq_q;

    ////////////////////////////////////////
    // button and interrupt requests
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            btn_meta_q <= 1'b0;
            btn_sync_q <= 1'b0;
            btn_prev_q <= 1'b0;
            irq_q      <= '0;
        end
        else begin
            btn_meta_q <= button_i;
            btn_sync_q <= btn_meta_q;
            btn_prev_q <= btn_sync_q;
            if (btn_sync_q && !btn_prev_q) begin
                irq_q[IRQ_BUTTON] <= 1'b1;
            end
            else if (iack_i[IRQ_BUTTON]) begin
                irq_q[IRQ_BUTTON] <= 1'b0;
            end
            if (uart_done) begin
                irq_q[IRQ_UART] <= 1'b1;
            end
            else if (iack_i[IRQ_UART]) begin
                irq_q[IRQ_UART] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                PER_BUTTON:      rdata_o <= {31'b0, btn_sync_q};
                PER_UART_STATUS: rdata_o <= {31'b0, uart_busy};
                default:         rdata_o <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // uart
    ////////////////////////////////////////
    uart_tx u_uart_tx (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (uart_start),
        .data_i   (mem_req_i.wdata[7:0]),
        .tx_o     (uart_tx_o),
        .busy_o   (uart_busy),
        .done_o   (uart_done)
    );

endmodule

//--- hdl/uart_tx.sv
module uart_tx (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  logic [7:0] data_i,
    output logic       tx_o,
    output logic       busy_o,
    output logic       done_o
);
    import soc_pkg::*;

    logic [FRAME_BITS-1:0] shift_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [BAUD_W-1:0]     baud_cnt_q;
    logic                  busy_q;
    logic                  done_q;
    logic                  bit_end;

    assign bit_end = (baud_cnt_q == BAUD_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end
        else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q     <= 1'b1;
                bit_cnt_q  <= '0;
                baud_cnt_q <= '0;
            end
            else if (busy_q) begin
                if (bit_end) begin
                    baud_cnt_q <= '0;
                    if (bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1)) begin
                        busy_q <= 1'b0;  // end of stop bit
                        done_q <= 1'b1;
                    end
                    else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                else begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end
            end
        end
    end

    // frame goes out lsb first
    always_ff @(posedge clk) begin
        if (start_i) begin
            shift_q <= {1'b1, data_i, 1'b0};
        end
        else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
        end
    end

    assign tx_o   = busy_q ? shift_q[0] : 1'b1;  // line idles high
    assign busy_o = busy_q;
    assign done_o = done_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !busy_q);

endmodule

//--- hdl/irq_controller.sv
module irq_controller (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        en_i,
    input  soc_pkg::mem_req_t           mem_req_i,
    output logic [31:0]                 rdata_o,
    input  logic [soc_pkg::IRQ_COUNT:1] irq_i,
    input  logic                        interrupt_ack_i,
    output logic                        mei_o,
    output logic [soc_pkg::IRQ_COUNT:1] iack_o
);
    import soc_pkg::*;

    logic [IRQ_COUNT:1]  pending_q;
    logic [IRQ_COUNT:1]  enable_q;
    logic [IRQ_COUNT:1]  irq_q;       // previous request level
    logic [IRQ_COUNT:1]  active;
    logic [IRQ_ID_W-1:0] claim_id;
    logic [IRQ_ID_W-1:0] claimed_q;
    logic                rd;
    logic                wr;
    logic [7:0]          offset;

    assign offset = mem_req_i.addr[7:0];
    assign rd     = en_i && !(|mem_req_i.we);
    assign wr     = en_i && (|mem_req_i.we);
    assign active = pending_q & enable_q;
    assign mei_o  = |active;

    // lowest enabled pending id wins
    always_comb begin
        claim_id = '0;
        for (int i = IRQ_COUNT; i >= 1; i--) begin
            if (active[i]) begin
                claim_id = IRQ_ID_W'(i);
            end
        end
    end

    // ack goes back to the claimed source only
    always_comb begin
        for (int i = 1; i <= IRQ_COUNT; i++) begin
            iack_o[i] = interrupt_ack_i && (claimed_q == IRQ_ID_W'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            enable_q  <= '0;
            irq_q     <= '0;
            claimed_q <= '0;
        end
        else begin
            irq_q     <= irq_i;
            pending_q <= (pending_q & ~iack_o) | (irq_i & ~irq_q);  // rising request sets
            if (wr && offset == PLIC_ENABLE && mem_req_i.we[0]) begin
                enable_q <= mem_req_i.wdata[IRQ_COUNT-1:0];
            end
            if (rd && offset == PLIC_CLAIM) begin
                claimed_q <= claim_id;
            end
            else if (interrupt_ack_i) begin
                claimed_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                PLIC_PENDING: rdata_o <= 32'(pending_q);
                PLIC_ENABLE:  rdata_o <= 32'(enable_q);
                PLIC_CLAIM:   rdata_o <= 32'(claim_id);
                default:      rdata_o <= '0;
            endcase
        end
    end

    a_iack_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(iack_o));

    // an ack only reaches a source whose interrupt is still pending
    a_iack_pending: assert property (@(posedge clk) disable iff (!arst_n_i)
        (|iack_o) |-> (|(iack_o & pending_q)));

endmodule

//--- hdl/machine_timer.sv
module machine_timer (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              en_i,
    input  soc_pkg::mem_req_t mem_req_i,
    output logic [31:0]       rdata_o,
    output logic              mti_o
);
    import soc_pkg::*;

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        wr;
    logic        rd;
    logic [7:0]  offset;

    assign offset = mem_req_i.addr[7:0];
    assign wr     = en_i && (|mem_req_i.we);
    assign rd     = en_i && !(|mem_req_i.we);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // no timer interrupt until programmed
        end
        else begin
            mtime_q <= mtime_q + 64'd1;
            // a written half overrides the increment
            if (wr) begin
                case (offset)
                    MTIME_LO:    mtime_q[31:0]     <= merge_bytes(mtime_q[31:0],
                                                        mem_req_i.wdata, mem_req_i.we);
                    MTIME_HI:    mtime_q[63:32]    <= merge_bytes(mtime_q[63:32],
                                                        mem_req_i.wdata, mem_req_i.we);
                    MTIMECMP_LO: mtimecmp_q[31:0]  <= merge_bytes(mtimecmp_q[31:0],
                                                        mem_req_i.wdata, mem_req_i.we);
                    MTIMECMP_HI: mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32],
                                                        mem_req_i.wdata, mem_req_i.we);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                MTIME_LO:    rdata_o <= mtime_q[31:0];
                MTIME_HI:    rdata_o <= mtime_q[63:32];
                MTIMECMP_LO: rdata_o <= mtimecmp_q[31:0];
                MTIMECMP_HI: rdata_o <= mtimecmp_q[63:32];
                default:     rdata_o <= '0;
            endcase
        end
    end

    assign mti_o = (mtime_q >= mtimecmp_q);

endmodule

//--- hdl/data_ram.sv
module data_ram (
    input  logic              clk,
    input  logic              en_i,
    input  soc_pkg::mem_req_t mem_req_i,
    output logic [31:0]       rdata_o
);
    import soc_pkg::*;

    logic [31:0]          mem [RAM_WORDS];
    logic [RAM_IDX_W-1:0] idx;

    assign idx = mem_req_i.addr[RAM_IDX_W+1:2];  // word index

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (|mem_req_i.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_req_i.we[i]) begin
                        mem[idx][8*i +: 8] <= mem_req_i.wdata[8*i +: 8];
                    end
                end
            end
            else begin
                rdata_o <= mem[idx];  // valid the cycle after the read
            end
        end
    end

endmodule

//--- hdl/bus_decoder.sv
module bus_decoder (
    input  logic              clk,
    input  logic              arst_n_i,
    input  soc_pkg::mem_req_t mem_req_i,
    output logic              ram_en_o,
    output logic              rtc_en_o,
    output logic              plic_en_o,
    output logic              per_en_o,
    input  logic [31:0]       ram_rdata_i,
    input  logic [31:0]       rtc_rdata_i,
    input  logic [31:0]       plic_rdata_i,
    input  logic [31:0]       per_rdata_i,
    output logic [31:0]       rdata_o
);
    import soc_pkg::*;

    logic [3:0] region;
    logic       rtc_sel_q;
    logic       plic_sel_q;
    logic       per_sel_q;

    assign region = mem_req_i.addr[31:28];

    always_comb begin
        ram_en_o  = 1'b0;
        rtc_en_o  = 1'b0;
        plic_en_o = 1'b0;
        per_en_o  = 1'b0;
        if (mem_req_i.en) begin
            if (region < REGION_RAM_END) begin
                ram_en_o = 1'b1;
            end
            else if (region < REGION_RTC_END) begin
                rtc_en_o = 1'b1;
            end
            else if (region < REGION_PLIC_END) begin
                plic_en_o = 1'b1;
            end
            else begin
                per_en_o = 1'b1;  // everything above the interrupt controller
            end
        end
    end

    // remember the target for the data returned next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
            per_sel_q  <= 1'b0;
        end
        else begin
            rtc_sel_q  <= rtc_en_o;
            plic_sel_q <= plic_en_o;
            per_sel_q  <= per_en_o;
        end
    end

    always_comb begin
        if (rtc_sel_q) begin
            rdata_o = rtc_rdata_i;
        end
        else if (plic_sel_q) begin
            rdata_o = plic_rdata_i;
        end
        else if (per_sel_q) begin
            rdata_o = per_rdata_i;
        end
        else begin
            rdata_o = ram_rdata_i;  // ram is the default source
        end
    end

    a_one_target: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({ram_en_o, rtc_en_o, plic_en_o, per_en_o}));

endmodule

//--- hdl/soc_pkg.sv
package soc_pkg;

    // one data-bus request, held by the master while stalled
    typedef struct packed {
        logic        en;
        logic [3:0]  we;     // byte strobes, all zero for a read
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // region ends, compared against addr[31:28]
    localparam logic [3:0] REGION_RAM_END  = 4'h2;
    localparam logic [3:0] REGION_RTC_END  = 4'h3;
    localparam logic [3:0] REGION_PLIC_END = 4'h8;

    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    localparam int IRQ_COUNT  = 2;
    localparam int IRQ_ID_W   = $clog2(IRQ_COUNT + 1);  // id 0 means none
    localparam int IRQ_BUTTON = 1;
    localparam int IRQ_UART   = 2;

    localparam int CLKS_PER_BIT = 8;                     // short bit time for simulation
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS   = 10;                    // start, 8 data, stop
    localparam int BIT_CNT_W    = $clog2(FRAME_BITS);

    // register offsets, low address byte
    localparam logic [7:0] MTIME_LO        = 8'h00;
    localparam logic [7:0] MTIME_HI        = 8'h04;
    localparam logic [7:0] MTIMECMP_LO     = 8'h08;
    localparam logic [7:0] MTIMECMP_HI     = 8'h0C;
    localparam logic [7:0] PLIC_PENDING    = 8'h00;
    localparam logic [7:0] PLIC_ENABLE     = 8'h04;
    localparam logic [7:0] PLIC_CLAIM      = 8'h08;
    localparam logic [7:0] PER_BUTTON      = 8'h00;
    localparam logic [7:0] PER_UART_DATA   = 8'h04;
    localparam logic [7:0] PER_UART_STATUS = 8'h08;

    // byte-lane merge of a write into an existing word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  we);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage
